// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= chip_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
rtl/chip_pkg.sv
rtl/uart.sv
rtl/program_loader.sv
rtl/inst_memory.sv
rtl/core.sv
rtl/boot_control.sv
rtl/chip.sv
testbench/clock_gen.sv
testbench/chip_checker.sv
testbench/chip_tb.sv

// ==== rtl/boot_control.sv ====
module boot_control (
	input logic clk,
	input logic rst_n,
	input logic done,
	output logic loader_rst,
	output logic core_rst,
	output logic loaded,
	input logic [7:0] ldr_tx_data,
	input logic ldr_tx_valid,
	input logic [7:0] core_tx_data,
	input logic core_tx_valid,
	output logic [7:0] tx_data,
	output logic tx_valid
);
	import chip_pkg::*;

	logic [4:0] rst_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rst_cnt <= boot_reset_cycles;
			loader_rst <= 1'b1;
			loaded <= 1'b0;
		end else begin
			if (rst_cnt != 5'd0) begin
				rst_cnt <= rst_cnt - 5'd1;
			end
			loader_rst <= rst_cnt != 5'd0;  // high for boot_reset_cycles after rst_n rises
			if (done) begin
				loaded <= 1'b1;
			end
		end
	end

	assign core_rst = !loaded;

	// the loader owns the line until its acknowledge has gone out
	assign tx_data = loaded ? core_tx_data : ldr_tx_data;
	assign tx_valid = loaded ? core_tx_valid : ldr_tx_valid;

endmodule

// ==== rtl/chip.sv ====
module chip (
	input logic clk,
	input logic rst_n,
	input logic uart_rx,
	output logic uart_tx,
	output logic loaded,
	output logic halted,
	output logic lost
);
	import chip_pkg::*;

	logic loader_rst;
	logic core_rst;
	logic done;

	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_ready;

	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_ready;
	logic [7:0] ldr_tx_data;
	logic ldr_tx_valid;
	logic [7:0] core_tx_data;
	logic core_tx_valid;

	logic we;
	logic [inst_addr_bits-1:0] waddr;
	logic [31:0] wdata;
	logic [inst_addr_bits-1:0] raddr;
	logic [31:0] rdata;

	uart u_uart (
		.clk(clk),
		.rst_n(rst_n),
		.rx(uart_rx),
		.tx(uart_tx),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.lost(lost)
	);

	program_loader u_loader (
		.clk(clk),
		.rst(loader_rst),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.tx_data(ldr_tx_data),
		.tx_valid(ldr_tx_valid),
		.tx_ready(tx_ready),
		.done(done)
	);

	inst_memory u_imem (
		.clk(clk),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.raddr(raddr),
		.rdata(rdata)
	);

	core u_core (
		.clk(clk),
		.rst(core_rst),
		.raddr(raddr),
		.rdata(rdata),
		.tx_data(core_tx_data),
		.tx_valid(core_tx_valid),
		.tx_ready(tx_ready),
		.halted(halted)
	);

	boot_control u_boot (
		.clk(clk),
		.rst_n(rst_n),
		.done(done),
		.loader_rst(loader_rst),
		.core_rst(core_rst),
		.loaded(loaded),
		.ldr_tx_data(ldr_tx_data),
		.ldr_tx_valid(ldr_tx_valid),
		.core_tx_data(core_tx_data),
		.core_tx_valid(core_tx_valid),
		.tx_data(tx_data),
		.tx_valid(tx_valid)
	);

endmodule

// ==== rtl/chip_pkg.sv ====
package chip_pkg;

	localparam logic [15:0] clks_per_bit = 16'd8;  // uart bit time in clk cycles
	localparam logic [4:0] boot_reset_cycles = 5'd15;
	localparam int inst_addr_bits = 6;
	localparam logic [7:0] ack_byte = 8'h06;

	// program loader states
	localparam logic [2:0] ld_count = 3'd0;
	localparam logic [2:0] ld_bytes = 3'd1;
	localparam logic [2:0] ld_write = 3'd2;
	localparam logic [2:0] ld_ack = 3'd3;
	localparam logic [2:0] ld_fin = 3'd4;

	typedef enum logic [3:0] {
		op_ldi = 4'h1,
		op_addi = 4'h2,
		op_ldc = 4'h3,
		op_out = 4'h4,
		op_djnz = 4'h5,
		op_halt = 4'hf
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [19:0] unused;
		logic [7:0] imm;
	} imm_view_t;

	typedef struct packed {
		opcode_e opcode;
		logic [27-inst_addr_bits:0] unused;
		logic [inst_addr_bits-1:0] target;
	} jump_view_t;

	typedef union packed {
		imm_view_t imm_view;
		jump_view_t jump_view;  // only op_djnz is decoded this way
	} instr_u;

endpackage

// ==== rtl/core.sv ====
module core (
	input logic clk,
	input logic rst,
	output logic [chip_pkg::inst_addr_bits-1:0] raddr,
	input logic [31:0] rdata,
	output logic [7:0] tx_data,
	output logic tx_valid,
	input logic tx_ready,
	output logic halted
);
	import chip_pkg::*;

	instr_u instr;
	logic execute;
	logic [inst_addr_bits-1:0] pc;
	logic [7:0] acc;
	logic [7:0] loop_cnt;
	logic [7:0] loop_next;

	assign instr = rdata;
	assign raddr = pc;  // the memory registers the word during the fetch cycle
	assign loop_next = loop_cnt - 8'd1;
	assign tx_data = acc;
	assign tx_valid = execute && instr.imm_view.opcode == op_out;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			execute <= 1'b0;
			acc <= 8'd0;
			loop_cnt <= 8'd0;
			halted <= 1'b0;
		end else if (!halted) begin
			if (!execute) begin
				execute <= 1'b1;
			end else begin
				execute <= 1'b0;
				pc <= pc + 1'b1;
				case (instr.imm_view.opcode)
					op_ldi: acc <= instr.imm_view.imm;
					op_addi: acc <= acc + instr.imm_view.imm;  // wraps at 8 bits
					op_ldc: loop_cnt <= instr.imm_view.imm;
					op_out: if (!tx_ready) begin
						execute <= 1'b1;  // stay in execute until the transmitter takes the byte
						pc <= pc;
					end
					op_djnz: begin
						loop_cnt <= loop_next;
						if (loop_next != 8'd0) begin
							pc <= instr.jump_view.target;
						end
					end
					op_halt: begin
						halted <= 1'b1;
						pc <= pc;  // leave pc on the halt for debug
					end
					default: ;  // unknown codes just advance the pc
				endcase
			end
		end
	end

endmodule

// ==== rtl/inst_memory.sv ====
module inst_memory (
	input logic clk,
	input logic we,
	input logic [chip_pkg::inst_addr_bits-1:0] waddr,
	input logic [31:0] wdata,
	input logic [chip_pkg::inst_addr_bits-1:0] raddr,
	output logic [31:0] rdata
);
	import chip_pkg::*;

	logic [31:0] mem [0:(1 << inst_addr_bits) - 1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read data shows up one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== rtl/program_loader.sv ====
module program_loader (
	input logic clk,
	input logic rst,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output logic rx_ready,
	output logic we,
	output logic [chip_pkg::inst_addr_bits-1:0] waddr,
	output logic [31:0] wdata,
	output logic [7:0] tx_data,
	output logic tx_valid,
	input logic tx_ready,
	output logic done
);
	import chip_pkg::*;

	logic [2:0] state;
	logic [1:0] byte_idx;
	logic [inst_addr_bits-1:0] last_addr;

	assign rx_ready = state == ld_count || state == ld_bytes;
	assign we = state == ld_write;
	assign tx_valid = state == ld_ack;
	assign tx_data = ack_byte;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ld_count;
			byte_idx <= 2'd0;
			waddr <= '0;
			last_addr <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ld_count: if (rx_valid) begin
					last_addr <= rx_data[inst_addr_bits-1:0] - 1'b1;  // a count of 64 wraps to 63
					state <= ld_bytes;
				end
				ld_bytes: if (rx_valid) begin
					byte_idx <= byte_idx + 2'd1;
					if (byte_idx == 2'd3) begin
						state <= ld_write;
					end
				end
				ld_write: if (waddr == last_addr) begin
					state <= ld_ack;
				end else begin
					waddr <= waddr + 1'b1;
					state <= ld_bytes;
				end
				ld_ack: if (tx_ready) begin
					done <= 1'b1;
					state <= ld_fin;
				end
				default: ;  // finished, only a reset leaves this state
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ld_bytes && rx_valid) begin
			wdata <= {rx_data, wdata[31:8]};  // bytes arrive lsb first
		end
	end

endmodule

// ==== rtl/uart.sv ====
module uart (
	input logic clk,
	input logic rst_n,
	input logic rx,
	output logic tx,
	output logic [7:0] rx_data,
	output logic rx_valid,
	input logic rx_ready,
	input logic [7:0] tx_data,
	input logic tx_valid,
	output logic tx_ready,
	output logic lost
);
	import chip_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_busy;
	logic [3:0] rx_bit;
	logic [15:0] rx_timer;
	logic [7:0] rx_shift;
	logic rx_done;
	logic rx_take;

	logic tx_busy;
	logic [3:0] tx_bit;
	logic [15:0] tx_timer;
	logic [8:0] tx_shift;

	// the frame ends at the middle of a good stop bit
	assign rx_done = rx_busy && rx_timer == 16'd0 && rx_bit == 4'd9 && rx_sync;
	assign rx_take = rx_done && (!rx_valid || rx_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_busy <= 1'b0;
			rx_bit <= 4'd0;
			rx_timer <= 16'd0;
		end else if (!rx_busy) begin
			if (!rx_sync) begin
				rx_busy <= 1'b1;
				rx_bit <= 4'd0;
				rx_timer <= (clks_per_bit >> 1) - 16'd1;  // half a bit to reach the middle
			end
		end else if (rx_timer != 16'd0) begin
			rx_timer <= rx_timer - 16'd1;
		end else begin
			rx_timer <= clks_per_bit - 16'd1;
			if (rx_bit == 4'd0 && rx_sync) begin
				rx_busy <= 1'b0;  // start bit did not hold, treat as a glitch
			end else if (rx_bit == 4'd9) begin
				rx_busy <= 1'b0;
			end else begin
				rx_bit <= rx_bit + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_busy && rx_timer == 16'd0 && rx_bit != 4'd0 && rx_bit != 4'd9) begin
			rx_shift <= {rx_sync, rx_shift[7:1]};  // lsb arrives first
		end
	end

	always_ff @(posedge clk) begin
		if (rx_take) begin
			rx_data <= rx_shift;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
			lost <= 1'b0;
		end else begin
			if (rx_valid && rx_ready) begin
				rx_valid <= 1'b0;
			end
			if (rx_take) begin
				rx_valid <= 1'b1;
			end else if (rx_done) begin
				lost <= 1'b1;  // held byte not taken yet, so the new one is dropped
			end
		end
	end

	assign tx_ready = !tx_busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			tx_bit <= 4'd0;
			tx_timer <= 16'd0;
		end else if (!tx_busy) begin
			if (tx_valid) begin
				tx <= 1'b0;
				tx_busy <= 1'b1;
				tx_bit <= 4'd0;
				tx_timer <= clks_per_bit - 16'd1;
			end
		end else if (tx_timer != 16'd0) begin
			tx_timer <= tx_timer - 16'd1;
		end else if (tx_bit == 4'd9) begin
			tx_busy <= 1'b0;  // stop bit has been on the line for a full bit
		end else begin
			tx <= tx_shift[0];
			tx_bit <= tx_bit + 4'd1;
			tx_timer <= clks_per_bit - 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!tx_busy && tx_valid) begin
			tx_shift <= {1'b1, tx_data};  // stop bit sits above the data
		end else if (tx_busy && tx_timer == 16'd0) begin
			tx_shift <= {1'b1, tx_shift[8:1]};
		end
	end

endmodule

// ==== testbench/chip_checker.sv ====
module chip_checker (
	input logic clk,
	input logic rst_n,
	input logic uart_tx,
	input logic tx_valid,
	input logic loaded,
	input logic halted,
	input logic lost
);
	timeunit 1ns;
	timeprecision 100ps;
	import chip_pkg::*;

	int fail_count = 0;
	logic reset_values;

	assign reset_values = uart_tx && !loaded && !halted && !lost;

	reset_outputs: assert property (@(posedge clk)
		$rose(rst_n) |-> reset_values ##1 reset_values ##1 reset_values)
	else begin
		fail_count++;
		$error("outputs left their reset values in the first cycles after reset");
	end

	loaded_holds: assert property (@(posedge clk) disable iff (!rst_n) loaded |=> loaded)
	else begin
		fail_count++;
		$error("loaded fell after it had risen");
	end

	halted_holds: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
	else begin
		fail_count++;
		$error("halted fell after it had risen");
	end

	// a halted core must never ask for the transmitter
	halted_quiet: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !tx_valid)
	else begin
		fail_count++;
		$error("tx_valid was high while halted");
	end

	// the last frame before the halt has ended well within twelve bit times
	halted_line_idle: assert property (@(posedge clk) disable iff (!rst_n)
		halted && $past(halted, 12 * clks_per_bit) |-> uart_tx)
	else begin
		fail_count++;
		$error("uart_tx left idle long after halt");
	end

	lost_holds: assert property (@(posedge clk) disable iff (!rst_n) lost |=> lost)
	else begin
		fail_count++;
		$error("lost fell before reset");
	end

endmodule

bind chip chip_checker chk0 (
	.clk(clk),
	.rst_n(rst_n),
	.uart_tx(uart_tx),
	.tx_valid(tx_valid),
	.loaded(loaded),
	.halted(halted),
	.lost(lost)
);

// ==== testbench/chip_tb.sv ====
module chip_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import chip_pkg::*;

	localparam int byte_timeout = 20000;
	localparam int flag_timeout = 2000;
	localparam int straight_outs = 4;

	logic clk;
	logic rst_n;
	logic uart_rx;
	logic uart_tx;
	logic loaded;
	logic halted;
	logic lost;

	logic [15:0] lfsr = 16'd95;
	logic [31:0] program_words [$];
	logic [7:0] expected [$];
	int errors = 0;
	int seen_failures = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	clock_gen clk0 (.clk(clk), .rst_n(rst_n));

	chip dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.loaded(loaded),
		.halted(halted),
		.lost(lost)
	);

	// taps 16, 14, 13 and 11, one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] value;
		value = 8'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			value = {value[6:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] make_word(input opcode_e op, input logic [7:0] arg);
		return {op, 20'd0, arg};  // a jump target fits in the low bits of arg
	endfunction

	function automatic logic status_bit(input int sel);
		case (sel)
			0: return rst_n;
			1: return loaded;
			2: return halted;
			default: return lost;
		endcase
	endfunction

	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 uart_rx = frame[i];
			repeat (clks_per_bit - 1) @(posedge clk);
		end
	endtask

	task automatic send_program();
		send_byte(8'(program_words.size()));
		foreach (program_words[i]) begin
			for (int b = 0; b < 4; b++) begin
				send_byte(program_words[i][8 * b +: 8]);  // least significant byte first
			end
		end
	endtask

	task automatic capture_byte(output logic [7:0] value, output logic got);
		int waited;
		value = 8'd0;
		got = 1'b0;
		waited = 0;
		@(negedge clk);
		while (uart_tx && waited < byte_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (uart_tx) begin
			$display("no start bit on uart_tx within %0d cycles", byte_timeout);
			errors++;
			return;
		end
		repeat (clks_per_bit / 2) @(negedge clk);  // middle of the start bit
		if (uart_tx) begin
			$display("start bit on uart_tx was too short");
			errors++;
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			value[i] = uart_tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		if (!uart_tx) begin
			$display("stop bit missing on uart_tx");
			errors++;
			return;
		end
		got = 1'b1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] want, input logic [7:0] seen);
		if (seen !== want) begin
			$display("Fail %s: expected %02h, actual %02h", name, want, seen);
			errors++;
		end
	endtask

	task automatic wait_status(input int sel, input string name);
		int waited;
		waited = 0;
		while (!status_bit(sel) && waited < flag_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (!status_bit(sel)) begin
			$display("%s did not go high within %0d cycles", name, flag_timeout);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int total;
		total = errors + dut0.chk0.fail_count;
		if (total == seen_failures) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d failed checks", name, total - seen_failures);
		end
		seen_failures = total;
	endtask

	initial begin
		logic [7:0] got_byte;
		logic got;
		logic [7:0] acc;
		logic [7:0] step;
		logic [7:0] loop_count;
		int loop_start;
		uart_rx = 1'b1;

		acc = rand_bits(8);
		program_words.push_back(make_word(op_ldi, acc));
		for (int i = 0; i < straight_outs; i++) begin
			step = rand_bits(8);
			acc = acc + step;  // wraps at 8 bits
			program_words.push_back(make_word(op_addi, step));
			program_words.push_back(make_word(op_out, 8'd0));
			expected.push_back(acc);
		end
		loop_count = 8'd3 + rand_bits(2);
		step = rand_bits(8);
		program_words.push_back(make_word(op_ldc, loop_count));
		loop_start = program_words.size();
		program_words.push_back(make_word(op_addi, step));
		program_words.push_back(make_word(op_out, 8'd0));
		program_words.push_back(make_word(op_djnz, 8'(loop_start)));
		program_words.push_back(make_word(op_halt, 8'd0));
		for (int j = 0; j < loop_count; j++) begin
			acc = acc + step;
			expected.push_back(acc);
		end

		wait_status(0, "rst_n");
		repeat (boot_reset_cycles + 4) @(posedge clk);  // loader leaves its stretched reset
		end_test("reset");

		fork
			send_program();
			capture_byte(got_byte, got);
		join
		if (got) begin
			check_byte("load", 8'h06, got_byte);
		end
		wait_status(1, "loaded");
		end_test("load");

		for (int i = 0; i < straight_outs; i++) begin
			capture_byte(got_byte, got);
			if (got) begin
				check_byte("straight", expected[i], got_byte);
			end
		end
		end_test("straight");

		for (int j = 0; j < loop_count; j++) begin
			capture_byte(got_byte, got);
			if (got) begin
				check_byte("loop", expected[straight_outs + j], got_byte);
			end
		end
		end_test("loop");

		// the line must stay quiet from the last loop byte on
		for (int i = 0; i < 12 * clks_per_bit; i++) begin
			@(negedge clk);
			if (!uart_tx) begin
				$display("uart_tx sent a start bit after the last expected byte");
				errors++;
				break;
			end
		end
		wait_status(2, "halted");
		end_test("halt");

		send_byte(rand_bits(8));
		send_byte(rand_bits(8));  // the first byte is still held, so this one is dropped
		wait_status(3, "lost");
		repeat (20) @(posedge clk);
		end_test("lost");

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_ok, tests_bad, seen_failures);
		if (seen_failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/clock_gen.sv ====
module clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;  // released just after the edge like the other inputs
	end

endmodule
